// ==== rtl/sched_cfg_pkg.sv ====
// Warp scheduler sizing
package sched_cfg_pkg;

    // warps in the core and lanes per warp
    localparam int NUM_WARPS   = 4;
    localparam int NUM_THREADS = 4;

    // program counters hold word addresses
    localparam int PC_BITS = 30;

    // local barrier slots
    localparam int NUM_BARRIERS = 4;

    // index widths
    localparam int NW_BITS = $clog2(NUM_WARPS);
    localparam int NB_BITS = $clog2(NUM_BARRIERS);

    // barrier generation counter, also the width of an arrive token
    localparam int GEN_BITS = 8;

endpackage

// ==== rtl/sched_msg_pkg.sv ====
// Warp scheduler message types
package sched_msg_pkg;

    // warp control opcodes
    typedef enum logic [1:0] {
        CTL_TMC        = 2'd0,
        CTL_WSPAWN     = 2'd1,
        CTL_BAR_ARRIVE = 2'd2,
        CTL_BAR_WAIT   = 2'd3
    } ctl_op_e;

    // warp control request from execute
    typedef struct packed {
        logic                                  valid;
        ctl_op_e                               op;
        logic [sched_cfg_pkg::NW_BITS-1:0]     wid;
        // new thread mask for TMC
        logic [sched_cfg_pkg::NUM_THREADS-1:0] tmask;
        // warps to start on WSPAWN, and their entry pc
        logic [sched_cfg_pkg::NUM_WARPS-1:0]   wmask;
        logic [sched_cfg_pkg::PC_BITS-1:0]     pc;
        logic [sched_cfg_pkg::NB_BITS-1:0]     bar_id;
        // expected warps minus one
        logic [sched_cfg_pkg::NW_BITS-1:0]     bar_count;
        logic [sched_cfg_pkg::GEN_BITS-1:0]    token;
    } warp_ctl_t;

    // branch resolution from the ALU
    typedef struct packed {
        logic                              valid;
        logic [sched_cfg_pkg::NW_BITS-1:0] wid;
        logic                              taken;
        logic [sched_cfg_pkg::PC_BITS-1:0] dest;
    } branch_t;

    // per-warp update applied at the next edge
    typedef struct packed {
        logic                                  unlock;
        logic                                  issue;
        logic                                  set_tmask;
        logic [sched_cfg_pkg::NUM_THREADS-1:0] tmask;
        logic                                  set_pc;
        logic [sched_cfg_pkg::PC_BITS-1:0]     pc;
    } warp_event_t;

    // issued warp, towards fetch
    typedef struct packed {
        logic [sched_cfg_pkg::NW_BITS-1:0]     wid;
        logic [sched_cfg_pkg::NUM_THREADS-1:0] tmask;
        logic [sched_cfg_pkg::PC_BITS-1:0]     pc;
    } sched_out_t;

endpackage

// ==== rtl/warp_event_router.sv ====
// Warp event router
module warp_event_router (
    input  logic                                         clk,
    input  logic                                         reset,
    input  sched_msg_pkg::warp_ctl_t                     ctl,
    input  sched_msg_pkg::branch_t                       branch,
    input  logic                                         unlock_valid,
    input  logic [sched_cfg_pkg::NW_BITS-1:0]            unlock_wid,
    input  logic [sched_cfg_pkg::NUM_WARPS-1:0]          wake,
    input  logic                                         wait_pass,
    input  logic [sched_cfg_pkg::NUM_WARPS-1:0]          active,
    input  logic                                         pick_valid,
    input  logic [sched_cfg_pkg::NW_BITS-1:0]            pick_wid,
    output sched_msg_pkg::warp_event_t [sched_cfg_pkg::NUM_WARPS-1:0] events
);

    typedef struct packed {
        logic                                valid;
        logic [sched_cfg_pkg::NW_BITS-1:0]   wid;
        logic [sched_cfg_pkg::NUM_WARPS-1:0] wmask;
        logic [sched_cfg_pkg::PC_BITS-1:0]   pc;
    } spawn_t;

    spawn_t                              spawn_q;
    logic                                single_active;
    logic                                spawn_fire;
    logic [sched_cfg_pkg::NUM_WARPS-1:0] unlock_mask;
    logic [sched_cfg_pkg::NUM_WARPS-1:0] issued_q;

    // exactly one bit set in the active mask
    assign single_active = (active != '0) && ((active & (active - 1'b1)) == '0);
    assign spawn_fire    = spawn_q.valid && single_active;

    always_comb begin
        events = '0;
        if (ctl.valid) begin
            case (ctl.op)
                sched_msg_pkg::CTL_TMC: begin
                    events[ctl.wid].set_tmask = 1'b1;
                    events[ctl.wid].tmask     = ctl.tmask;
                    events[ctl.wid].unlock    = 1'b1;
                end
                sched_msg_pkg::CTL_BAR_ARRIVE: events[ctl.wid].unlock = 1'b1;
                sched_msg_pkg::CTL_BAR_WAIT:   events[ctl.wid].unlock = wait_pass;
                // spawner stays locked until the spawn is applied
                default: ;
            endcase
        end
        if (branch.valid) begin
            events[branch.wid].unlock = 1'b1;
            if (branch.taken) begin
                events[branch.wid].set_pc = 1'b1;
                events[branch.wid].pc     = branch.dest;
            end
        end
        if (unlock_valid) begin
            events[unlock_wid].unlock = 1'b1;
        end
        for (int w = 0; w < sched_cfg_pkg::NUM_WARPS; w++) begin
            if (wake[w]) begin
                events[w].unlock = 1'b1;
            end
            if (spawn_fire && spawn_q.wmask[w]) begin
                events[w].set_tmask = 1'b1;
                events[w].tmask     = sched_cfg_pkg::NUM_THREADS'(1);
                events[w].set_pc    = 1'b1;
                events[w].pc        = spawn_q.pc;
                events[w].unlock    = 1'b1;
            end
        end
        if (spawn_fire) begin
            events[spawn_q.wid].unlock = 1'b1;
        end
        if (pick_valid) begin
            events[pick_wid].issue = 1'b1;
        end
        for (int w = 0; w < sched_cfg_pkg::NUM_WARPS; w++) begin
            unlock_mask[w] = events[w].unlock;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            spawn_q.valid <= 1'b0;
        end else begin
            if (spawn_fire) begin
                spawn_q.valid <= 1'b0;
            end
            if (ctl.valid && ctl.op == sched_msg_pkg::CTL_WSPAWN) begin
                spawn_q <= '{valid: 1'b1, wid: ctl.wid, wmask: ctl.wmask, pc: ctl.pc};
            end
        end
    end

    // warps issued and still waiting for their unlock
    always_ff @(posedge clk) begin
        if (reset) begin
            issued_q <= '0;
        end else begin
            issued_q <= (issued_q & ~unlock_mask)
                      | (pick_valid ? (sched_cfg_pkg::NUM_WARPS'(1) << pick_wid) : '0);
        end
    end

    // requests may only come back for a warp that was issued and not yet released
    a_target_stalled: assert property (@(posedge clk) disable iff (reset)
        (!ctl.valid || issued_q[ctl.wid])
        && (!branch.valid || issued_q[branch.wid])
        && (!unlock_valid || issued_q[unlock_wid]));

endmodule

// ==== rtl/warp_slot.sv ====
// Single warp state slot
module warp_slot #(
    // slot that runs out of reset
    parameter bit BOOT = 1'b0
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic [sched_cfg_pkg::PC_BITS-1:0]     start_pc,
    input  sched_msg_pkg::warp_event_t            evt,
    output logic                                  active,
    output logic                                  ready,
    output logic [sched_cfg_pkg::NUM_THREADS-1:0] tmask,
    output logic [sched_cfg_pkg::PC_BITS-1:0]     pc
);

    logic [sched_cfg_pkg::NUM_THREADS-1:0] tmask_q;
    logic [sched_cfg_pkg::PC_BITS-1:0]     pc_q;
    logic                                  stalled_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            // boot warp starts with lane 0 only
            tmask_q   <= BOOT ? sched_cfg_pkg::NUM_THREADS'(1) : '0;
            pc_q      <= start_pc;
            stalled_q <= 1'b0;
        end else begin
            if (evt.set_tmask) begin
                tmask_q <= evt.tmask;
            end

            // redirect wins over the sequential advance
            if (evt.set_pc) begin
                pc_q <= evt.pc;
            end else if (evt.issue) begin
                pc_q <= pc_q + sched_cfg_pkg::PC_BITS'(1);
            end

            // held until decode, branch or control releases it
            if (evt.issue) begin
                stalled_q <= 1'b1;
            end else if (evt.unlock) begin
                stalled_q <= 1'b0;
            end
        end
    end

    // a warp with no live lanes is inactive
    assign active = (tmask_q != '0);
    assign ready  = active && !stalled_q;
    assign tmask  = tmask_q;
    assign pc     = pc_q;

endmodule

// ==== rtl/barrier_table.sv ====
// Local barrier table
module barrier_table (
    input  logic                                 clk,
    input  logic                                 reset,
    input  sched_msg_pkg::warp_ctl_t             ctl,
    output logic [sched_cfg_pkg::NUM_WARPS-1:0]  wake,
    output logic                                 wait_pass,
    output logic [sched_cfg_pkg::GEN_BITS-1:0]   arrive_token
);

    // per barrier arrivals, generation and waiting warps
    logic [sched_cfg_pkg::NUM_BARRIERS-1:0][sched_cfg_pkg::NW_BITS-1:0]   count_q;
    logic [sched_cfg_pkg::NUM_BARRIERS-1:0][sched_cfg_pkg::GEN_BITS-1:0]  gen_q;
    logic [sched_cfg_pkg::NUM_BARRIERS-1:0][sched_cfg_pkg::NUM_WARPS-1:0] waiting_q;

    logic                                       is_arrive;
    logic                                       is_wait;
    logic                                       last_arrival;
    logic signed [sched_cfg_pkg::GEN_BITS-1:0] gen_ahead;

    assign is_arrive = ctl.valid && (ctl.op == sched_msg_pkg::CTL_BAR_ARRIVE);
    assign is_wait   = ctl.valid && (ctl.op == sched_msg_pkg::CTL_BAR_WAIT);

    // bar_count is the expected number minus one
    assign last_arrival = (count_q[ctl.bar_id] == ctl.bar_count);

    // wrap-safe distance between generation and token
    assign gen_ahead = gen_q[ctl.bar_id] - ctl.token;

    // generation before this arrival
    assign arrive_token = gen_q[ctl.bar_id];
    assign wait_pass    = is_wait && (gen_ahead > 0);
    assign wake         = (is_arrive && last_arrival) ? waiting_q[ctl.bar_id] : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            count_q   <= '0;
            gen_q     <= '0;
            waiting_q <= '0;
        end else if (is_arrive) begin
            if (last_arrival) begin
                // last arrival starts the next generation
                count_q[ctl.bar_id]   <= '0;
                gen_q[ctl.bar_id]     <= gen_q[ctl.bar_id] + 1'b1;
                waiting_q[ctl.bar_id] <= '0;
            end else begin
                count_q[ctl.bar_id] <= count_q[ctl.bar_id] + 1'b1;
            end
        end else if (is_wait && !wait_pass) begin
            // park until the generation moves on
            waiting_q[ctl.bar_id][ctl.wid] <= 1'b1;
        end
    end

    // arrivals never overshoot the expected count of the barrier
    a_count_range: assert property (@(posedge clk) disable iff (reset)
        is_arrive |-> (count_q[ctl.bar_id] <= ctl.bar_count));

endmodule

// ==== rtl/warp_issue.sv ====
// Warp selection and output buffer
module warp_issue (
    input  logic                                                    clk,
    input  logic                                                    reset,
    input  logic [sched_cfg_pkg::NUM_WARPS-1:0]                     ready,
    input  logic [sched_cfg_pkg::NUM_WARPS-1:0][sched_cfg_pkg::NUM_THREADS-1:0] tmask,
    input  logic [sched_cfg_pkg::NUM_WARPS-1:0][sched_cfg_pkg::PC_BITS-1:0]     pc,
    output logic                                                    pick_valid,
    output logic [sched_cfg_pkg::NW_BITS-1:0]                       pick_wid,
    output logic                                                    out_valid,
    output sched_msg_pkg::sched_out_t                               out,
    input  logic                                                    out_ready
);

    logic                              sel_found;
    logic [sched_cfg_pkg::NW_BITS-1:0] sel_wid;

    // two-entry buffer, payload only
    sched_msg_pkg::sched_out_t [1:0]   buf_q;
    logic                              wr_ptr_q;
    logic                              rd_ptr_q;
    logic [1:0]                        count_q;
    logic                              push;
    logic                              pop;

    // lowest ready index wins
    always_comb begin
        sel_found = 1'b0;
        sel_wid   = '0;
        for (int w = sched_cfg_pkg::NUM_WARPS - 1; w >= 0; w--) begin
            if (ready[w]) begin
                sel_found = 1'b1;
                sel_wid   = sched_cfg_pkg::NW_BITS'(w);
            end
        end
    end

    // only take a warp when the buffer can hold it
    assign pick_valid = sel_found && (count_q != 2'd2);
    assign pick_wid   = sel_wid;

    assign push      = pick_valid;
    assign pop       = out_valid && out_ready;
    assign out_valid = (count_q != 2'd0);
    assign out       = buf_q[rd_ptr_q];

    always_ff @(posedge clk) begin
        if (push) begin
            buf_q[wr_ptr_q] <= '{wid: sel_wid, tmask: tmask[sel_wid], pc: pc[sel_wid]};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr_q <= 1'b0;
            rd_ptr_q <= 1'b0;
            count_q  <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr_q <= ~wr_ptr_q;
            end
            if (pop) begin
                rd_ptr_q <= ~rd_ptr_q;
            end
            count_q <= count_q + 2'(push) - 2'(pop);
        end
    end

    // fetch sees a held item unchanged
    a_out_stable: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out));

    // the slot stalls at the pick edge, so the same warp is not ready right after
    a_pick_stalls: assert property (@(posedge clk) disable iff (reset)
        pick_valid |=> !ready[$past(pick_wid)]);

endmodule

// ==== rtl/warp_scheduler.sv ====
// Warp scheduler top
module warp_scheduler (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [sched_cfg_pkg::PC_BITS-1:0]   start_pc,
    input  sched_msg_pkg::warp_ctl_t            ctl,
    input  sched_msg_pkg::branch_t              branch,
    input  logic                                unlock_valid,
    input  logic [sched_cfg_pkg::NW_BITS-1:0]   unlock_wid,
    input  logic                                out_ready,
    output logic                                out_valid,
    output sched_msg_pkg::sched_out_t           out,
    output logic [sched_cfg_pkg::GEN_BITS-1:0]  arrive_token,
    output logic                                busy
);

    sched_msg_pkg::warp_event_t [sched_cfg_pkg::NUM_WARPS-1:0]             events;
    logic [sched_cfg_pkg::NUM_WARPS-1:0]                                   active;
    logic [sched_cfg_pkg::NUM_WARPS-1:0]                                   ready;
    logic [sched_cfg_pkg::NUM_WARPS-1:0][sched_cfg_pkg::NUM_THREADS-1:0]   tmask;
    logic [sched_cfg_pkg::NUM_WARPS-1:0][sched_cfg_pkg::PC_BITS-1:0]       pc;
    logic [sched_cfg_pkg::NUM_WARPS-1:0]                                   wake;
    logic                                                                  wait_pass;
    logic                                                                  pick_valid;
    logic [sched_cfg_pkg::NW_BITS-1:0]                                     pick_wid;

    warp_event_router u_router (
        .clk          (clk),
        .reset        (reset),
        .ctl          (ctl),
        .branch       (branch),
        .unlock_valid (unlock_valid),
        .unlock_wid   (unlock_wid),
        .wake         (wake),
        .wait_pass    (wait_pass),
        .active       (active),
        .pick_valid   (pick_valid),
        .pick_wid     (pick_wid),
        .events       (events)
    );

    barrier_table u_barriers (
        .clk          (clk),
        .reset        (reset),
        .ctl          (ctl),
        .wake         (wake),
        .wait_pass    (wait_pass),
        .arrive_token (arrive_token)
    );

    // warp 0 boots at start_pc
    for (genvar w = 0; w < sched_cfg_pkg::NUM_WARPS; w++) begin : g_slot
        warp_slot #(
            .BOOT (w == 0)
        ) u_slot (
            .clk      (clk),
            .reset    (reset),
            .start_pc (start_pc),
            .evt      (events[w]),
            .active   (active[w]),
            .ready    (ready[w]),
            .tmask    (tmask[w]),
            .pc       (pc[w])
        );
    end

    warp_issue u_issue (
        .clk        (clk),
        .reset      (reset),
        .ready      (ready),
        .tmask      (tmask),
        .pc         (pc),
        .pick_valid (pick_valid),
        .pick_wid   (pick_wid),
        .out_valid  (out_valid),
        .out        (out),
        .out_ready  (out_ready)
    );

    // busy while any warp is active, high coming out of reset
    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b1;
        end else begin
            busy <= |active;
        end
    end

endmodule

// ==== testbench/sched_tests.svh ====
// Scheduler test table
// columns are kind, ctl op, wid, mask, pc, flag, bar_id, bar_count, value
// mask is the tmask (TMC, expected item) or the wmask (spawn)
// flag is branch taken or expected busy
// value is token or cycle count
localparam int NUM_ROWS = 31;

test_row_t tests [NUM_ROWS] = '{
    // boot warp at start_pc, then decode unlock
    '{ROW_OUT,    2'd0, 2'd0, 4'h1, 30'h100, 1'b0, 2'd0, 2'd0, 8'd0},
    '{ROW_UNLOCK, 2'd0, 2'd0, 4'h0, 30'h0,   1'b0, 2'd0, 2'd0, 8'd0},
    '{ROW_OUT,    2'd0, 2'd0, 4'h1, 30'h101, 1'b0, 2'd0, 2'd0, 8'd0},
    // taken branch, then not taken with a dest that must be ignored
    '{ROW_BRANCH, 2'd0, 2'd0, 4'h0, 30'h200, 1'b1, 2'd0, 2'd0, 8'd0},
    '{ROW_OUT,    2'd0, 2'd0, 4'h1, 30'h200, 1'b0, 2'd0, 2'd0, 8'd0},
    '{ROW_BRANCH, 2'd0, 2'd0, 4'h0, 30'h3f0, 1'b0, 2'd0, 2'd0, 8'd0},
    '{ROW_OUT,    2'd0, 2'd0, 4'h1, 30'h201, 1'b0, 2'd0, 2'd0, 8'd0},
    // new thread mask 1011
    '{ROW_CTL, sched_msg_pkg::CTL_TMC, 2'd0, 4'hb, 30'h0, 1'b0, 2'd0, 2'd0, 8'd0},
    '{ROW_OUT,    2'd0, 2'd0, 4'hb, 30'h202, 1'b0, 2'd0, 2'd0, 8'd0},
    // spawn warps 1 to 3 while the output is held
    '{ROW_CTL, sched_msg_pkg::CTL_WSPAWN, 2'd0, 4'he, 30'h300, 1'b0, 2'd0, 2'd0, 8'd0},
    '{ROW_STALL,  2'd0, 2'd0, 4'h0, 30'h0,   1'b0, 2'd0, 2'd0, 8'd6},
    '{ROW_OUT,    2'd0, 2'd0, 4'hb, 30'h203, 1'b0, 2'd0, 2'd0, 8'd0},
    '{ROW_OUT,    2'd0, 2'd1, 4'h1, 30'h300, 1'b0, 2'd0, 2'd0, 8'd0},
    '{ROW_OUT,    2'd0, 2'd2, 4'h1, 30'h300, 1'b0, 2'd0, 2'd0, 8'd0},
    '{ROW_OUT,    2'd0, 2'd3, 4'h1, 30'h300, 1'b0, 2'd0, 2'd0, 8'd0},
    // barrier 1 for two warps with warp 2 waiting before the second arrival
    '{ROW_CTL, sched_msg_pkg::CTL_BAR_ARRIVE, 2'd1, 4'h0, 30'h0, 1'b0, 2'd1, 2'd1, 8'd0},
    '{ROW_OUT,    2'd0, 2'd1, 4'h1, 30'h301, 1'b0, 2'd0, 2'd0, 8'd0},
    '{ROW_CTL, sched_msg_pkg::CTL_BAR_WAIT, 2'd2, 4'h0, 30'h0, 1'b0, 2'd1, 2'd1, 8'd0},
    '{ROW_QUIET,  2'd0, 2'd0, 4'h0, 30'h0,   1'b1, 2'd0, 2'd0, 8'd4},
    '{ROW_CTL, sched_msg_pkg::CTL_BAR_ARRIVE, 2'd3, 4'h0, 30'h0, 1'b0, 2'd1, 2'd1, 8'd0},
    '{ROW_OUT,    2'd0, 2'd2, 4'h1, 30'h301, 1'b0, 2'd0, 2'd0, 8'd0},
    '{ROW_OUT,    2'd0, 2'd3, 4'h1, 30'h301, 1'b0, 2'd0, 2'd0, 8'd0},
    // generation already past token 0
    '{ROW_CTL, sched_msg_pkg::CTL_BAR_WAIT, 2'd1, 4'h0, 30'h0, 1'b0, 2'd1, 2'd1, 8'd0},
    '{ROW_OUT,    2'd0, 2'd1, 4'h1, 30'h302, 1'b0, 2'd0, 2'd0, 8'd0},
    // retire every warp
    '{ROW_CTL, sched_msg_pkg::CTL_TMC, 2'd1, 4'h0, 30'h0, 1'b0, 2'd0, 2'd0, 8'd0},
    '{ROW_CTL, sched_msg_pkg::CTL_TMC, 2'd2, 4'h0, 30'h0, 1'b0, 2'd0, 2'd0, 8'd0},
    '{ROW_CTL, sched_msg_pkg::CTL_TMC, 2'd3, 4'h0, 30'h0, 1'b0, 2'd0, 2'd0, 8'd0},
    '{ROW_UNLOCK, 2'd0, 2'd0, 4'h0, 30'h0,   1'b0, 2'd0, 2'd0, 8'd0},
    '{ROW_OUT,    2'd0, 2'd0, 4'hb, 30'h204, 1'b0, 2'd0, 2'd0, 8'd0},
    '{ROW_CTL, sched_msg_pkg::CTL_TMC, 2'd0, 4'h0, 30'h0, 1'b0, 2'd0, 2'd0, 8'd0},
    '{ROW_QUIET,  2'd0, 2'd0, 4'h0, 30'h0,   1'b0, 2'd0, 2'd0, 8'd4}
};

// ==== testbench/tb_warp_scheduler.sv ====
// Warp scheduler testbench
module tb_warp_scheduler;

    typedef enum logic [2:0] {
        ROW_OUT, ROW_CTL, ROW_BRANCH, ROW_UNLOCK, ROW_STALL, ROW_QUIET
    } row_kind_e;

    // value is a WAIT token, an expected ARRIVE token or a cycle count
    typedef struct packed {
        row_kind_e                             kind;
        logic [1:0]                            op;
        logic [sched_cfg_pkg::NW_BITS-1:0]     wid;
        logic [sched_cfg_pkg::NUM_THREADS-1:0] mask;
        logic [sched_cfg_pkg::PC_BITS-1:0]     pc;
        logic                                  flag;
        logic [sched_cfg_pkg::NB_BITS-1:0]     bar_id;
        logic [sched_cfg_pkg::NW_BITS-1:0]     bar_count;
        logic [sched_cfg_pkg::GEN_BITS-1:0]    value;
    } test_row_t;

    `include "sched_tests.svh"

    localparam logic [sched_cfg_pkg::PC_BITS-1:0] START_PC = sched_cfg_pkg::PC_BITS'('h100);
    localparam int CYCLE_LIMIT = 16 + 40 * NUM_ROWS;

    logic                               clk = 1'b0;
    logic                               reset;
    logic [sched_cfg_pkg::PC_BITS-1:0]  start_pc;
    sched_msg_pkg::warp_ctl_t           ctl;
    sched_msg_pkg::branch_t             branch;
    logic                               unlock_valid;
    logic [sched_cfg_pkg::NW_BITS-1:0]  unlock_wid;
    logic                               out_ready;
    logic                               out_valid;
    sched_msg_pkg::sched_out_t          out;
    logic [sched_cfg_pkg::GEN_BITS-1:0] arrive_token;
    logic                               busy;

    logic [31:0] rng;
    int          cycles = 0;
    int          errors = 0;
    int          failed_rows = 0;

    warp_scheduler dut (.*);

    always #5 clk = ~clk;

    // run limit from the table length
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == CYCLE_LIMIT) begin
            $display("timeout: the tests did not finish within %0d cycles", cycles);
            $display("Done: errors found");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // inputs change just after the edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
        $display("** Error at %0t: %s is 'h%0h, expected 'h%0h", $time, name, got, exp);
        errors++;
    endtask

    task automatic apply_row(input test_row_t r);
        sched_msg_pkg::sched_out_t item;
        logic                      moved;
        case (r.kind)
            ROW_OUT: begin
                // random back-pressure until the item transfers
                moved = 1'b0;
                while (!moved) begin
                    rng       = next_rand(rng);
                    out_ready = rng[9];
                    moved     = out_valid && out_ready;
                    item      = out;
                    step();
                end
                out_ready = 1'b0;
                if (item.wid != r.wid) mismatch("out.wid", 32'(item.wid), 32'(r.wid));
                if (item.tmask != r.mask) mismatch("out.tmask", 32'(item.tmask), 32'(r.mask));
                if (item.pc != r.pc) mismatch("out.pc", 32'(item.pc), 32'(r.pc));
            end
            ROW_CTL: begin
                ctl = '{valid: 1'b1, op: sched_msg_pkg::ctl_op_e'(r.op), wid: r.wid,
                        tmask: r.mask, wmask: r.mask, pc: r.pc, bar_id: r.bar_id,
                        bar_count: r.bar_count, token: r.value};
                #1;
                // token shows the generation before this arrival
                if (r.op == sched_msg_pkg::CTL_BAR_ARRIVE && arrive_token != r.value) begin
                    mismatch("arrive_token", 32'(arrive_token), 32'(r.value));
                end
                step();
                ctl = '0;
            end
            ROW_BRANCH: begin
                branch = '{valid: 1'b1, wid: r.wid, taken: r.flag, dest: r.pc};
                step();
                branch = '0;
            end
            ROW_UNLOCK: begin
                unlock_valid = 1'b1;
                unlock_wid   = r.wid;
                step();
                unlock_valid = 1'b0;
            end
            ROW_STALL: begin
                out_ready = 1'b0;
                repeat (r.value) step();
            end
            default: begin
                // nothing may come out
                out_ready = 1'b1;
                repeat (r.value) begin
                    if (out_valid) begin
                        $display("unexpected item from warp %0d at %0t", out.wid, $time);
                        errors++;
                    end
                    step();
                end
                out_ready = 1'b0;
                if (busy != r.flag) mismatch("busy", 32'(busy), 32'(r.flag));
            end
        endcase
    endtask

    initial begin
        int        errors_before;
        row_kind_e kind;
        reset        = 1'b1;
        start_pc     = START_PC;
        ctl          = '0;
        branch       = '0;
        unlock_valid = 1'b0;
        unlock_wid   = '0;
        out_ready    = 1'b0;
        rng          = 32'h834d_fb02;
        repeat (16) @(posedge clk);
        #1;
        // boot warp is live, nothing issued yet
        if (out_valid) begin
            $display("out_valid is high during reset at %0t", $time);
            errors++;
        end
        if (busy != 1'b1) mismatch("busy", 32'(busy), 32'd1);
        $display("reset: %s", errors == 0 ? "ok" : "failed");
        reset = 1'b0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            errors_before = errors;
            kind          = tests[i].kind;
            apply_row(tests[i]);
            if (errors != errors_before) failed_rows++;
            $display("row %0d %s: %s", i, kind.name(), errors == errors_before ? "ok" : "failed");
        end
        $display("%0d rows, %0d failed, %0d errors", NUM_ROWS, failed_rows, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+testbench
rtl/sched_cfg_pkg.sv
rtl/sched_msg_pkg.sv
rtl/warp_event_router.sv
rtl/warp_slot.sv
rtl/barrier_table.sv
rtl/warp_issue.sv
rtl/warp_scheduler.sv
testbench/tb_warp_scheduler.sv

// ==== Makefile ====
VERILATOR ?= verilator
FILELIST  ?= sim.f
TB_TOP    ?= tb_warp_scheduler
RTL_TOP   ?= warp_scheduler
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS ?= --lint-only -Wall
PASS_MSG  ?= Done: no errors

SOURCES  := $(filter-out +%,$(shell cat $(FILELIST))) testbench/sched_tests.svh
RTL_SRCS := $(filter rtl/%,$(SOURCES))

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TB_TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

run: $(OBJ_DIR)/V$(TB_TOP)
	@out="$$($(OBJ_DIR)/V$(TB_TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR)
